// File: src/camcent_pkg.sv
// camera centroid shared types
package camcent_pkg;

  localparam int COL_W = 8;  // up to 256 columns
  localparam int ROW_W = 7;  // up to 128 rows

  // channel thresholds for color classification
  localparam logic [3:0] CH_HIGH = 4'd10;
  localparam logic [3:0] CH_LOW  = 4'd5;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb444_t;

  // one pixel moving down the pipeline
  typedef struct packed {
    logic             valid;  // single cycle strobe
    rgb444_t          pxl;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             last;   // final pixel of the frame
  } pxl_beat_t;

  typedef enum logic [1:0] {
    FILT_NONE,
    FILT_RED,
    FILT_GREEN,
    FILT_BLUE
  } filt_mode_e;

  typedef enum logic [1:0] {
    CAP_WAIT_FRAME,
    CAP_BYTE_HI,
    CAP_BYTE_LO
  } cap_state_e;

endpackage

// File: src/ov7670_capture.sv
// ov7670 pixel capture
`timescale 1ns/1ps

module ov7670_capture import camcent_pkg::*; #(
  parameter int img_cols = 160,
  parameter int img_rows = 120,
  parameter bit swap_rb  = 1'b1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pclk,
  input  logic       vsync,
  input  logic       href,
  input  logic [7:0] cam_data,
  output pxl_beat_t  cap_beat
);

  logic [2:0]       ctl_s1;      // {vsync, href, pclk}
  logic [2:0]       ctl_s2;
  logic [7:0]       data_s1;
  logic [7:0]       data_s2;
  logic [7:0]       data_q;
  logic             pclk_prev;
  logic             vsync_prev;  // also the vsync level at the edge stage
  logic             pclk_rise;
  logic             vsync_rise;
  logic             vsync_fall;
  logic             href_q;

  cap_state_e       state;
  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic [3:0]       red_nib;     // low nibble of the first byte
  logic             byte_hit;
  logic             end_col;
  logic             end_frame;
  rgb444_t          pxl_in;

  // two sync flops then a registered edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctl_s1     <= '0;
      ctl_s2     <= '0;
      pclk_prev  <= 1'b0;
      vsync_prev <= 1'b0;
      pclk_rise  <= 1'b0;
      vsync_rise <= 1'b0;
      vsync_fall <= 1'b0;
      href_q     <= 1'b0;
    end else begin
      ctl_s1     <= {vsync, href, pclk};
      ctl_s2     <= ctl_s1;
      pclk_prev  <= ctl_s2[0];
      vsync_prev <= ctl_s2[2];
      pclk_rise  <= ctl_s2[0] & ~pclk_prev;
      vsync_rise <= ctl_s2[2] & ~vsync_prev;
      vsync_fall <= ~ctl_s2[2] & vsync_prev;
      href_q     <= ctl_s2[1];
    end
  end

  // byte bus delayed to line up with pclk_rise
  always_ff @(posedge clk) begin
    data_s1 <= cam_data;
    data_s2 <= data_s1;
    data_q  <= data_s2;
  end

  assign byte_hit  = pclk_rise & href_q;  // bytes outside href dropped
  assign end_col   = (col_cnt == COL_W'(img_cols - 1));
  assign end_frame = end_col && (row_cnt == ROW_W'(img_rows - 1));

  // second byte holds green and blue
  always_comb begin
    pxl_in.green = data_q[7:4];
    if (swap_rb) begin
      pxl_in.red  = data_q[3:0];
      pxl_in.blue = red_nib;
    end else begin
      pxl_in.red  = red_nib;
      pxl_in.blue = data_q[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (state == CAP_BYTE_HI && byte_hit)
      red_nib <= data_q[3:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CAP_WAIT_FRAME;
      col_cnt  <= '0;
      row_cnt  <= '0;
      cap_beat <= '0;
    end else begin
      cap_beat.valid <= 1'b0;
      if (vsync_rise) begin  // restart, even mid frame
        state   <= CAP_WAIT_FRAME;
        col_cnt <= '0;
        row_cnt <= '0;
      end else begin
        unique case (state)
          CAP_WAIT_FRAME: begin
            if (vsync_fall)
              state <= CAP_BYTE_HI;
          end
          CAP_BYTE_HI: begin
            if (byte_hit)
              state <= CAP_BYTE_LO;
          end
          CAP_BYTE_LO: begin
            if (byte_hit) begin
              cap_beat <= '{valid: 1'b1, pxl: pxl_in, col: col_cnt,
                            row: row_cnt, last: end_frame};
              state    <= end_frame ? CAP_WAIT_FRAME : CAP_BYTE_HI;
              if (end_col) begin
                col_cnt <= '0;
                row_cnt <= end_frame ? '0 : row_cnt + 1'b1;
              end else begin
                col_cnt <= col_cnt + 1'b1;
              end
            end
          end
          default: state <= CAP_WAIT_FRAME;
        endcase
      end
    end
  end

endmodule

// File: src/color_filter.sv
// color filter stage
`timescale 1ns/1ps

module color_filter import camcent_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       proc_ctrl,
  input  pxl_beat_t  cap_beat,
  output pxl_beat_t  proc_beat,
  output logic       match,
  output filt_mode_e filt_mode
);

  logic [2:0] btn_sync;  // two sync flops plus previous level
  logic       btn_rise;
  logic       hit;

  // selected channel strong, the other two weak
  function automatic logic dominant(input logic [3:0] sel,
                                    input logic [3:0] oth_a,
                                    input logic [3:0] oth_b);
    return (sel >= CH_HIGH) && (oth_a <= CH_LOW) && (oth_b <= CH_LOW);
  endfunction

  assign btn_rise = btn_sync[1] & ~btn_sync[2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      btn_sync  <= '0;
      filt_mode <= FILT_NONE;
    end else begin
      btn_sync <= {btn_sync[1:0], proc_ctrl};
      if (btn_rise)
        filt_mode <= filt_mode_e'(filt_mode + 2'd1);  // BLUE wraps to NONE
    end
  end

  always_comb begin
    unique case (filt_mode)
      FILT_RED:   hit = dominant(cap_beat.pxl.red, cap_beat.pxl.green, cap_beat.pxl.blue);
      FILT_GREEN: hit = dominant(cap_beat.pxl.green, cap_beat.pxl.red, cap_beat.pxl.blue);
      FILT_BLUE:  hit = dominant(cap_beat.pxl.blue, cap_beat.pxl.red, cap_beat.pxl.green);
      default:    hit = 1'b0;
    endcase
  end

  // one register stage, position fields copied through
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      proc_beat <= '0;
      match     <= 1'b0;
    end else begin
      proc_beat <= cap_beat;
      match     <= cap_beat.valid & hit;
      if (filt_mode != FILT_NONE && !hit)
        proc_beat.pxl <= '0;  // black out the rest
    end
  end

endmodule

// File: src/centroid_calc.sv
// frame centroid and proximity
`timescale 1ns/1ps

module centroid_calc import camcent_pkg::*; #(
  parameter int img_cols   = 160,
  parameter int img_rows   = 120,
  parameter int prox_shift = 11
) (
  input  logic       clk,
  input  logic       rst_n,
  input  pxl_beat_t  proc_beat,
  input  logic       match,
  output logic [7:0] centroid,
  output logic [2:0] proximity,
  output logic       found,
  output logic       result_valid
);

  localparam int CNT_W = $clog2(img_cols * img_rows + 1);
  localparam int SUM_W = CNT_W + COL_W;  // column sum never overflows

  logic [SUM_W-1:0] acc_sum;
  logic [SUM_W-1:0] sum_next;
  logic [CNT_W-1:0] acc_cnt;
  logic [CNT_W-1:0] cnt_next;
  logic             frame_start;
  logic             snap;

  logic [SUM_W-1:0] rem;       // running remainder
  logic [SUM_W-1:0] dvs;       // count, shifted down each step
  logic [CNT_W-1:0] cnt_snap;
  logic [7:0]       quo;
  logic [2:0]       step;
  logic             busy;
  logic             done;
  logic [CNT_W-1:0] prox_full;

  // pixel 0,0 starts fresh, drops leftovers of a cut frame
  assign frame_start = (proc_beat.col == '0) && (proc_beat.row == '0);
  assign snap        = proc_beat.valid & proc_beat.last;

  always_comb begin
    sum_next = frame_start ? '0 : acc_sum;
    cnt_next = frame_start ? '0 : acc_cnt;
    if (match) begin
      sum_next = sum_next + SUM_W'(proc_beat.col);
      cnt_next = cnt_next + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_sum <= '0;
      acc_cnt <= '0;
    end else if (proc_beat.valid) begin
      if (proc_beat.last) begin
        acc_sum <= '0;
        acc_cnt <= '0;
      end else begin
        acc_sum <= sum_next;
        acc_cnt <= cnt_next;
      end
    end
  end

  // restoring divider, one quotient bit per cycle, msb first
  always_ff @(posedge clk) begin
    if (snap) begin
      rem      <= sum_next;
      dvs      <= SUM_W'(cnt_next) << 7;
      cnt_snap <= cnt_next;
    end else if (busy) begin
      if (rem >= dvs) begin
        rem <= rem - dvs;
        quo <= {quo[6:0], 1'b1};
      end else begin
        quo <= {quo[6:0], 1'b0};
      end
      dvs <= dvs >> 1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (snap) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == 3'd7) begin  // eighth bit done
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  assign prox_full = cnt_snap >> prox_shift;

  // results held until the next frame ends
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      centroid     <= '0;
      proximity    <= '0;
      found        <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= done;
      if (done) begin
        found     <= (cnt_snap != '0);
        centroid  <= (cnt_snap != '0) ? quo : '0;  // zero divisor gives all ones
        proximity <= (prox_full > 7) ? 3'd7 : prox_full[2:0];
      end
    end
  end

endmodule

// File: src/camera_centroid_top.sv
// camera centroid tracker top
`timescale 1ns/1ps

module camera_centroid_top import camcent_pkg::*; #(
  parameter int img_cols   = 160,  // QQVGA
  parameter int img_rows   = 120,
  parameter bit swap_rb    = 1'b1, // sensor sends red and blue swapped
  parameter int prox_shift = 11
) (
  input  logic       clk,
  input  logic       rst_n,
  // camera
  input  logic       pclk,
  input  logic       vsync,
  input  logic       href,
  input  logic [7:0] cam_data,
  // filter select button
  input  logic       proc_ctrl,
  output pxl_beat_t  proc_beat,
  output filt_mode_e filt_mode,
  output logic [7:0] centroid,
  output logic [2:0] proximity,
  output logic       found,
  output logic       result_valid
);

  pxl_beat_t cap_beat;
  logic      match;

  ov7670_capture #(
    .img_cols (img_cols),
    .img_rows (img_rows),
    .swap_rb  (swap_rb)
  ) capture_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pclk     (pclk),
    .vsync    (vsync),
    .href     (href),
    .cam_data (cam_data),
    .cap_beat (cap_beat)
  );

  color_filter filter_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .proc_ctrl (proc_ctrl),
    .cap_beat  (cap_beat),
    .proc_beat (proc_beat),
    .match     (match),
    .filt_mode (filt_mode)
  );

  centroid_calc #(
    .img_cols     (img_cols),
    .img_rows     (img_rows),
    .prox_shift   (prox_shift)
  ) centroid_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .proc_beat    (proc_beat),
    .match        (match),
    .centroid     (centroid),
    .proximity    (proximity),
    .found        (found),
    .result_valid (result_valid)
  );

endmodule

// File: test/tb_camera_centroid.sv
// camera centroid testbench
`timescale 1ns/1ps

module tb_camera_centroid import camcent_pkg::*; ();

  localparam int COLS = 8;
  localparam int ROWS = 4;

  typedef struct packed {
    logic [7:0] centroid;
    logic [2:0] proximity;
    logic       found;
  } result_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       pclk;
  logic       vsync;
  logic       href;
  logic [7:0] cam_data;
  logic       proc_ctrl;
  pxl_beat_t  proc_beat;
  filt_mode_e filt_mode;
  logic [7:0] centroid;
  logic [2:0] proximity;
  logic       found;
  logic       result_valid;

  pxl_beat_t  exp_beat_q[$];
  result_t    exp_res_q[$];
  rgb444_t    frm_q[$];        // pixels of the frame being collected in sensor order
  int         mode_model = 0;  // 0 none, 1 red, 2 green, 3 blue
  int         seed = 32'h546198ef;
  int         cyc = 0;
  int         last_beat_cyc = 0;
  int         mismatch_cnt = 0;
  int         other_err = 0;
  bit         aborted = 1'b0;

  camera_centroid_top #(
    .img_cols   (COLS),
    .img_rows   (ROWS),
    .swap_rb    (1'b1),
    .prox_shift (2)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pclk         (pclk),
    .vsync        (vsync),
    .href         (href),
    .cam_data     (cam_data),
    .proc_ctrl    (proc_ctrl),
    .proc_beat    (proc_beat),
    .filt_mode    (filt_mode),
    .centroid     (centroid),
    .proximity    (proximity),
    .found        (found),
    .result_valid (result_valid)
  );

  always #5 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
      mismatch_cnt++;
    end
  endtask

  // threshold rule on the pixel after the red/blue swap
  function automatic logic pixel_matches(input int mode, input rgb444_t p);
    case (mode)
      1:       return (p.red >= CH_HIGH) && (p.green <= CH_LOW) && (p.blue <= CH_LOW);
      2:       return (p.green >= CH_HIGH) && (p.red <= CH_LOW) && (p.blue <= CH_LOW);
      3:       return (p.blue >= CH_HIGH) && (p.red <= CH_LOW) && (p.green <= CH_LOW);
      default: return 1'b0;
    endcase
  endfunction

  // one pclk period of four clk cycles with byte and href set on the rising edge
  task automatic pclk_cycle(input logic [7:0] data, input logic href_lvl, input logic vs_lvl);
    @(posedge clk);
    pclk     <= 1'b1;
    cam_data <= data;
    href     <= href_lvl;
    vsync    <= vs_lvl;
    repeat (2) @(posedge clk);
    pclk <= 1'b0;
    @(posedge clk);
  endtask

  task automatic press_button();
    @(posedge clk);
    proc_ctrl <= 1'b1;
    repeat (4) @(posedge clk);
    proc_ctrl <= 1'b0;
    repeat (4) @(posedge clk);
    mode_model = (mode_model + 1) % 4;  // BLUE wraps to NONE
    @(negedge clk);
    check(filt_mode, mode_model, "filt_mode after button press");
  endtask

  // camera model that predicts each beat before its bytes go out
  task automatic send_frame(input result_t res);
    pxl_beat_t   exp_b;
    rgb444_t     swapped;
    logic [31:0] rnd;
    int          idx;
    exp_res_q.push_back(res);
    pclk_cycle(8'h00, 1'b0, 1'b1);  // vsync pulse
    pclk_cycle(8'h00, 1'b0, 1'b0);
    for (idx = 0; idx < COLS * ROWS; idx++) begin
      swapped = '{red: frm_q[idx].blue, green: frm_q[idx].green, blue: frm_q[idx].red};
      exp_b.valid = 1'b1;
      exp_b.col   = COL_W'(idx % COLS);
      exp_b.row   = ROW_W'(idx / COLS);
      exp_b.last  = (idx == COLS * ROWS - 1);
      if (mode_model == 0 || pixel_matches(mode_model, swapped))
        exp_b.pxl = swapped;
      else
        exp_b.pxl = '0;
      exp_beat_q.push_back(exp_b);
      rnd = $random(seed);
      pclk_cycle({rnd[3:0], frm_q[idx].red}, 1'b1, 1'b0);  // high nibble unused
      pclk_cycle({frm_q[idx].green, frm_q[idx].blue}, 1'b1, 1'b0);
      if (idx % COLS == COLS - 1 && idx != COLS * ROWS - 1)
        pclk_cycle(rnd[15:8], 1'b0, 1'b0);  // line blanking byte that must not make a beat
    end
    href <= 1'b0;
  endtask

  task automatic wait_pipeline_idle();
    int n;
    n = 0;
    while (exp_beat_q.size() > 0 && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (exp_beat_q.size() > 0) begin
      $display("timeout: proc_beat.valid never came for %0d pixels", exp_beat_q.size());
      other_err++;
      aborted = 1'b1;
    end
    n = 0;
    while (exp_res_q.size() > 0 && n < 200) begin
      @(posedge clk);
      n++;
    end
    if (exp_res_q.size() > 0) begin
      $display("timeout: result_valid never came for %0d frames", exp_res_q.size());
      other_err++;
      aborted = 1'b1;
    end
  endtask

  // beats and results compared in order
  always @(negedge clk) begin
    pxl_beat_t exp_b;
    result_t   exp_r;
    if (rst_n && proc_beat.valid) begin
      if (exp_beat_q.size() == 0) begin
        $display("proc_beat at %0t ns with no pixel sent", $time);
        other_err++;
      end else begin
        exp_b = exp_beat_q.pop_front();
        check(proc_beat.pxl, exp_b.pxl,
              $sformatf("pixel at col %0d row %0d", exp_b.col, exp_b.row));
        check(proc_beat.col, exp_b.col, "column");
        check(proc_beat.row, exp_b.row, "row");
        check(proc_beat.last, exp_b.last, "last flag");
        if (proc_beat.last)
          last_beat_cyc = cyc;
      end
    end
    if (rst_n && result_valid) begin
      if (exp_res_q.size() == 0) begin
        $display("result_valid at %0t ns with no frame pending", $time);
        other_err++;
      end else begin
        exp_r = exp_res_q.pop_front();
        check(centroid, exp_r.centroid, "centroid");
        check(proximity, exp_r.proximity, "proximity");
        check(found, exp_r.found, "found");
        check(cyc - last_beat_cyc, 10, "cycles from last proc_beat to result_valid");
      end
    end
  end

  initial begin
    int    fd;
    int    n;
    int    a, b, c, d;
    string line;
    string args;
    byte   cmd;
    rst_n     = 1'b0;
    pclk      = 1'b0;
    vsync     = 1'b0;
    href      = 1'b0;
    cam_data  = 8'h00;
    proc_ctrl = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) begin  // quiet until the first byte
      @(negedge clk);
      check(result_valid, 0, "result_valid after reset");
      check(proc_beat.valid, 0, "proc_beat.valid after reset");
      check(filt_mode, FILT_NONE, "filt_mode after reset");
    end
    fd = $fopen("test/centroid_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file test/centroid_patterns.txt");
      other_err++;
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        if (line.len() < 1)
          continue;
        cmd  = line[0];
        args = line.substr(1, line.len() - 1);
        n    = $sscanf(args, "%d %d %d %d", a, b, c, d);
        case (cmd)
          "M": begin
            wait_pipeline_idle();
            repeat (a) press_button();
          end
          "F": frm_q.delete();
          "P": repeat ((n >= 4) ? d : 1)
                 frm_q.push_back('{red: a[3:0], green: b[3:0], blue: c[3:0]});
          "E": begin
            if (frm_q.size() != COLS * ROWS) begin
              $display("pattern frame has %0d pixels instead of %0d", frm_q.size(), COLS * ROWS);
              other_err++;
            end else begin
              send_frame('{centroid: a[7:0], proximity: b[2:0], found: c[0]});
            end
          end
          default: ;  // comment or blank line
        endcase
      end
      $fclose(fd);
      wait_pipeline_idle();
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_err);
    if (mismatch_cnt == 0 && other_err == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: test/centroid_patterns.txt
# M n: press the filter button n times, F: start a frame, E c p f: expected result
# P r g b [n]: one pixel in sensor order before the red/blue swap, repeated n times
F
P 3 7 9 32
E 0 0 0
M 1
F
P 2 2 2 2
P 0 1 12 3
P 15 0 0 5
P 5 5 10 4
P 6 0 15 9
P 0 0 11 1
P 0 6 9 8
E 3 2 1
F
P 0 0 15 16
P 5 5 10 16
E 3 7 1
F
P 0 0 9 16
P 15 0 0 16
E 0 0 0
M 1
F
P 0 0 0 6
P 3 14 1 2
P 9 9 9 21
P 0 10 5 3
E 6 1 1
M 1
F
P 12 2 3 4
P 12 6 0 28
E 1 1 1
M 1

// File: filelist.f
src/camcent_pkg.sv
src/ov7670_capture.sv
src/color_filter.sv
src/centroid_calc.sv
src/camera_centroid_top.sv
test/tb_camera_centroid.sv

// File: Bender.yml
package:
  name: camera_centroid

sources:
  - src/camcent_pkg.sv
  - src/ov7670_capture.sv
  - src/color_filter.sv
  - src/centroid_calc.sv
  - src/camera_centroid_top.sv
  - target: test
    files:
      - test/tb_camera_centroid.sv
